//--- Bender.yml
package:
  name: glb_tile_cfg

sources:
  - glb_cfg_pkg.sv
  - glb_tile_cfg_ctrl.sv
  - glb_tile_cfg_regs.sv
  - glb_tile_cfg.sv
  - target: test
    files:
      - glb_tile_cfg_assert.sv
      - tb_glb_tile_cfg.sv

//--- glb_cfg_pkg.sv
`default_nettype none

package glb_cfg_pkg;

    // Chain and register widths
    localparam int TILE_ID_WIDTH   = 4;
    localparam int REG_ADDR_WIDTH  = 6;
    localparam int CFG_ADDR_WIDTH  = 12;
    localparam int CFG_DATA_WIDTH  = 32;
    localparam int CFG_BYTE_BITS   = 2;
    localparam int QUEUE_DEPTH     = 2;
    localparam int GLB_ADDR_WIDTH  = 16;
    localparam int NUM_WORDS_WIDTH = 16;
    localparam int LATENCY_WIDTH   = 5;

    typedef logic [TILE_ID_WIDTH-1:0]   tile_id_t;
    typedef logic [REG_ADDR_WIDTH-1:0]  reg_addr_t;
    typedef logic [CFG_ADDR_WIDTH-1:0]  cfg_addr_t;
    typedef logic [CFG_DATA_WIDTH-1:0]  cfg_data_t;
    typedef logic [GLB_ADDR_WIDTH-1:0]  glb_addr_t;
    typedef logic [NUM_WORDS_WIDTH-1:0] num_words_t;
    typedef logic [LATENCY_WIDTH-1:0]   latency_t;

    // Register word indices inside one tile
    localparam int REG_TILE_CTRL   = 0;
    localparam int REG_LATENCY     = 1;
    localparam int REG_ST_HDR_BASE = 2;
    localparam int REG_LD_HDR_BASE = 8;

    // Words per DMA header
    localparam int ST_HDR_WORDS = 3;
    localparam int LD_HDR_WORDS = 4;

    // Word offsets inside a header, stride only in load headers
    localparam int HDR_VALIDATE   = 0;
    localparam int HDR_START_ADDR = 1;
    localparam int HDR_NUM_WORDS  = 2;
    localparam int HDR_STRIDE     = 3;

    // Tile control word, the 2-bit fields are given by their low bit
    localparam int CTRL_TILE_CONNECTED = 0;
    localparam int CTRL_G2F_MUX_LSB    = 1;
    localparam int CTRL_F2G_MUX_LSB    = 3;
    localparam int CTRL_LD_MODE_LSB    = 5;
    localparam int CTRL_ST_MODE_LSB    = 7;
    localparam int CTRL_USE_VALID      = 9;

endpackage

`default_nettype wire

//--- glb_tile_cfg.f
glb_cfg_pkg.sv
glb_tile_cfg_ctrl.sv
glb_tile_cfg_regs.sv
glb_tile_cfg.sv
glb_tile_cfg_assert.sv
tb_glb_tile_cfg.sv

//--- glb_tile_cfg.sv
`timescale 1ns/1ns
`default_nettype none

module glb_tile_cfg (
    input  logic                   clk,
    input  logic                   arst_n,
    input  glb_cfg_pkg::tile_id_t  glb_tile_id,

    // Chain, west side
    input  logic                   cfg_wst_wr_en,
    input  logic                   cfg_wst_rd_en,
    input  glb_cfg_pkg::cfg_addr_t cfg_wst_addr,
    input  glb_cfg_pkg::cfg_data_t cfg_wst_data,
    output glb_cfg_pkg::cfg_data_t cfg_wst_rd_data,
    output logic                   cfg_wst_rd_data_valid,

    // Chain, east side
    output logic                   cfg_est_wr_en,
    output logic                   cfg_est_rd_en,
    output glb_cfg_pkg::cfg_addr_t cfg_est_addr,
    output glb_cfg_pkg::cfg_data_t cfg_est_data,
    input  glb_cfg_pkg::cfg_data_t cfg_est_rd_data,
    input  logic                   cfg_est_rd_data_valid,

    input  logic [glb_cfg_pkg::QUEUE_DEPTH-1:0] st_dma_invalidate_pulse,
    input  logic [glb_cfg_pkg::QUEUE_DEPTH-1:0] ld_dma_invalidate_pulse,

    // Configuration outputs
    output logic                   cfg_tile_connected,
    output logic [1:0]             cfg_strm_g2f_mux,
    output logic [1:0]             cfg_strm_f2g_mux,
    output logic [1:0]             cfg_ld_dma_mode,
    output logic [1:0]             cfg_st_dma_mode,
    output logic                   cfg_use_valid,
    output glb_cfg_pkg::latency_t  cfg_latency,
    output logic [glb_cfg_pkg::QUEUE_DEPTH-1:0] cfg_st_dma_valid,
    output glb_cfg_pkg::glb_addr_t  cfg_st_dma_start_addr [glb_cfg_pkg::QUEUE_DEPTH],
    output glb_cfg_pkg::num_words_t cfg_st_dma_num_words  [glb_cfg_pkg::QUEUE_DEPTH],
    output logic [glb_cfg_pkg::QUEUE_DEPTH-1:0] cfg_ld_dma_valid,
    output glb_cfg_pkg::glb_addr_t  cfg_ld_dma_start_addr [glb_cfg_pkg::QUEUE_DEPTH],
    output glb_cfg_pkg::num_words_t cfg_ld_dma_num_words  [glb_cfg_pkg::QUEUE_DEPTH],
    output glb_cfg_pkg::cfg_data_t  cfg_ld_dma_stride     [glb_cfg_pkg::QUEUE_DEPTH]
);

    import glb_cfg_pkg::*;

    // Controller to register file
    logic      reg_wr_en;
    logic      reg_rd_en;
    reg_addr_t reg_addr;
    cfg_data_t reg_wr_data;
    cfg_data_t reg_rd_data;

    glb_tile_cfg_ctrl u_ctrl (
        .clk                   (clk),
        .arst_n                (arst_n),
        .glb_tile_id           (glb_tile_id),
        .cfg_wst_wr_en         (cfg_wst_wr_en),
        .cfg_wst_rd_en         (cfg_wst_rd_en),
        .cfg_wst_addr          (cfg_wst_addr),
        .cfg_wst_data          (cfg_wst_data),
        .cfg_wst_rd_data       (cfg_wst_rd_data),
        .cfg_wst_rd_data_valid (cfg_wst_rd_data_valid),
        .cfg_est_wr_en         (cfg_est_wr_en),
        .cfg_est_rd_en         (cfg_est_rd_en),
        .cfg_est_addr          (cfg_est_addr),
        .cfg_est_data          (cfg_est_data),
        .cfg_est_rd_data       (cfg_est_rd_data),
        .cfg_est_rd_data_valid (cfg_est_rd_data_valid),
        .reg_wr_en             (reg_wr_en),
        .reg_rd_en             (reg_rd_en),
        .reg_addr              (reg_addr),
        .reg_wr_data           (reg_wr_data),
        .reg_rd_data           (reg_rd_data)
    );

    glb_tile_cfg_regs u_regs (
        .clk                     (clk),
        .arst_n                  (arst_n),
        .reg_wr_en               (reg_wr_en),
        .reg_rd_en               (reg_rd_en),
        .reg_addr                (reg_addr),
        .reg_wr_data             (reg_wr_data),
        .reg_rd_data             (reg_rd_data),
        .st_dma_invalidate_pulse (st_dma_invalidate_pulse),
        .ld_dma_invalidate_pulse (ld_dma_invalidate_pulse),
        .cfg_tile_connected      (cfg_tile_connected),
        .cfg_strm_g2f_mux        (cfg_strm_g2f_mux),
        .cfg_strm_f2g_mux        (cfg_strm_f2g_mux),
        .cfg_ld_dma_mode         (cfg_ld_dma_mode),
        .cfg_st_dma_mode         (cfg_st_dma_mode),
        .cfg_use_valid           (cfg_use_valid),
        .cfg_latency             (cfg_latency),
        .cfg_st_dma_valid        (cfg_st_dma_valid),
        .cfg_st_dma_start_addr   (cfg_st_dma_start_addr),
        .cfg_st_dma_num_words    (cfg_st_dma_num_words),
        .cfg_ld_dma_valid        (cfg_ld_dma_valid),
        .cfg_ld_dma_start_addr   (cfg_ld_dma_start_addr),
        .cfg_ld_dma_num_words    (cfg_ld_dma_num_words),
        .cfg_ld_dma_stride       (cfg_ld_dma_stride)
    );

endmodule

`default_nettype wire

//--- glb_tile_cfg_assert.sv
`timescale 1ns/1ns
`default_nettype none

module glb_tile_cfg_assert (
    input logic clk,
    input logic arst_n,
    input logic cfg_wst_wr_en,
    input logic cfg_wst_rd_en,
    input logic cfg_est_wr_en,
    input logic cfg_est_rd_en,
    input logic cfg_wst_rd_data_valid,
    input logic cfg_est_rd_data_valid,
    input logic reg_rd_en
);

    int fail_count = 0;

    // Every request reaches the east one cycle after it enters
    est_follows_wst: assert property (@(posedge clk) disable iff (!arst_n)
        $past(arst_n) |-> (cfg_est_wr_en == $past(cfg_wst_wr_en)) &&
                          (cfg_est_rd_en == $past(cfg_wst_rd_en)))
        else begin
            $error("East strobes do not follow the west strobes");
            fail_count++;
        end

    // Strobes held low through reset, seen at release
    rd_valid_low_in_reset: assert property (@(posedge clk)
        $rose(arst_n) |-> !cfg_wst_rd_data_valid && !cfg_est_wr_en && !cfg_est_rd_en)
        else begin
            $error("Chain strobes are not cleared by reset");
            fail_count++;
        end

    // A correct chain never returns east data while this tile answers
    no_return_collision: assert property (@(posedge clk) disable iff (!arst_n)
        !(reg_rd_en && cfg_est_rd_data_valid))
        else begin
            $error("Local read collides with an east read return");
            fail_count++;
        end

endmodule

bind glb_tile_cfg glb_tile_cfg_assert u_assert (.*);

`default_nettype wire

//--- glb_tile_cfg_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module glb_tile_cfg_ctrl (
    input  logic                   clk,
    input  logic                   arst_n,
    input  glb_cfg_pkg::tile_id_t  glb_tile_id,

    // West side of the chain
    input  logic                   cfg_wst_wr_en,
    input  logic                   cfg_wst_rd_en,
    input  glb_cfg_pkg::cfg_addr_t cfg_wst_addr,
    input  glb_cfg_pkg::cfg_data_t cfg_wst_data,
    output glb_cfg_pkg::cfg_data_t cfg_wst_rd_data,
    output logic                   cfg_wst_rd_data_valid,

    // East side of the chain
    output logic                   cfg_est_wr_en,
    output logic                   cfg_est_rd_en,
    output glb_cfg_pkg::cfg_addr_t cfg_est_addr,
    output glb_cfg_pkg::cfg_data_t cfg_est_data,
    input  glb_cfg_pkg::cfg_data_t cfg_est_rd_data,
    input  logic                   cfg_est_rd_data_valid,

    // Register file access
    output logic                   reg_wr_en,
    output logic                   reg_rd_en,
    output glb_cfg_pkg::reg_addr_t reg_addr,
    output glb_cfg_pkg::cfg_data_t reg_wr_data,
    input  glb_cfg_pkg::cfg_data_t reg_rd_data
);

    import glb_cfg_pkg::*;

    tile_id_t req_tile_id;
    logic     tile_hit;

    // One request stage, its outputs go straight east
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cfg_est_wr_en <= 1'b0;
            cfg_est_rd_en <= 1'b0;
            cfg_est_addr  <= '0;
            cfg_est_data  <= '0;
        end else begin
            cfg_est_wr_en <= cfg_wst_wr_en;
            cfg_est_rd_en <= cfg_wst_rd_en;
            cfg_est_addr  <= cfg_wst_addr;
            cfg_est_data  <= cfg_wst_data;
        end
    end

    // Tile id sits in the top bits of the address
    assign req_tile_id = cfg_est_addr[CFG_ADDR_WIDTH-1 -: TILE_ID_WIDTH];
    assign tile_hit    = (req_tile_id == glb_tile_id);

    // Local access decoded from the request stage
    assign reg_wr_en   = cfg_est_wr_en & tile_hit;
    assign reg_rd_en   = cfg_est_rd_en & tile_hit;
    assign reg_addr    = cfg_est_addr[CFG_BYTE_BITS +: REG_ADDR_WIDTH];
    assign reg_wr_data = cfg_est_data;

    // Read return towards the west
    // Local data wins over an east return in the same cycle
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cfg_wst_rd_data       <= '0;
            cfg_wst_rd_data_valid <= 1'b0;
        end else if (reg_rd_en) begin
            cfg_wst_rd_data       <= reg_rd_data;
            cfg_wst_rd_data_valid <= 1'b1;
        end else if (cfg_est_rd_data_valid) begin
            cfg_wst_rd_data       <= cfg_est_rd_data;
            cfg_wst_rd_data_valid <= 1'b1;
        end else begin
            cfg_wst_rd_data_valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- glb_tile_cfg_regs.sv
`timescale 1ns/1ns
`default_nettype none

module glb_tile_cfg_regs (
    input  logic                              clk,
    input  logic                              arst_n,

    // Access from the controller
    input  logic                              reg_wr_en,
    input  logic                              reg_rd_en,
    input  glb_cfg_pkg::reg_addr_t            reg_addr,
    input  glb_cfg_pkg::cfg_data_t            reg_wr_data,
    output glb_cfg_pkg::cfg_data_t            reg_rd_data,

    // Clear pulses from the DMA engines
    input  logic [glb_cfg_pkg::QUEUE_DEPTH-1:0] st_dma_invalidate_pulse,
    input  logic [glb_cfg_pkg::QUEUE_DEPTH-1:0] ld_dma_invalidate_pulse,

    // Tile control fields
    output logic                              cfg_tile_connected,
    output logic [1:0]                        cfg_strm_g2f_mux,
    output logic [1:0]                        cfg_strm_f2g_mux,
    output logic [1:0]                        cfg_ld_dma_mode,
    output logic [1:0]                        cfg_st_dma_mode,
    output logic                              cfg_use_valid,
    output glb_cfg_pkg::latency_t             cfg_latency,

    // DMA headers
    output logic [glb_cfg_pkg::QUEUE_DEPTH-1:0] cfg_st_dma_valid,
    output glb_cfg_pkg::glb_addr_t  cfg_st_dma_start_addr [glb_cfg_pkg::QUEUE_DEPTH],
    output glb_cfg_pkg::num_words_t cfg_st_dma_num_words  [glb_cfg_pkg::QUEUE_DEPTH],
    output logic [glb_cfg_pkg::QUEUE_DEPTH-1:0] cfg_ld_dma_valid,
    output glb_cfg_pkg::glb_addr_t  cfg_ld_dma_start_addr [glb_cfg_pkg::QUEUE_DEPTH],
    output glb_cfg_pkg::num_words_t cfg_ld_dma_num_words  [glb_cfg_pkg::QUEUE_DEPTH],
    output glb_cfg_pkg::cfg_data_t  cfg_ld_dma_stride     [glb_cfg_pkg::QUEUE_DEPTH]
);

    import glb_cfg_pkg::*;

    cfg_data_t rd_word;
    logic      ctrl_wr;
    logic      latency_wr;

    // Word index of one field of one queue entry
    function automatic reg_addr_t hdr_word(input int base, input int words,
                                           input int q, input int w);
        return reg_addr_t'(base + q * words + w);
    endfunction

    assign ctrl_wr    = reg_wr_en && (reg_addr == reg_addr_t'(REG_TILE_CTRL));
    assign latency_wr = reg_wr_en && (reg_addr == reg_addr_t'(REG_LATENCY));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cfg_tile_connected <= 1'b0;
            cfg_strm_g2f_mux   <= '0;
            cfg_strm_f2g_mux   <= '0;
            cfg_ld_dma_mode    <= '0;
            cfg_st_dma_mode    <= '0;
            cfg_use_valid      <= 1'b0;
        end else if (ctrl_wr) begin
            cfg_tile_connected <= reg_wr_data[CTRL_TILE_CONNECTED];
            cfg_strm_g2f_mux   <= reg_wr_data[CTRL_G2F_MUX_LSB +: 2];
            cfg_strm_f2g_mux   <= reg_wr_data[CTRL_F2G_MUX_LSB +: 2];
            cfg_ld_dma_mode    <= reg_wr_data[CTRL_LD_MODE_LSB +: 2];
            cfg_st_dma_mode    <= reg_wr_data[CTRL_ST_MODE_LSB +: 2];
            cfg_use_valid      <= reg_wr_data[CTRL_USE_VALID];
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cfg_latency <= '0;
        end else if (latency_wr) begin
            cfg_latency <= reg_wr_data[LATENCY_WIDTH-1:0];
        end
    end

    // Header queues, an invalidate pulse beats a write of the validate word
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cfg_st_dma_valid <= '0;
            cfg_ld_dma_valid <= '0;
            for (int q = 0; q < QUEUE_DEPTH; q++) begin
                cfg_st_dma_start_addr[q] <= '0;
                cfg_st_dma_num_words[q]  <= '0;
                cfg_ld_dma_start_addr[q] <= '0;
                cfg_ld_dma_num_words[q]  <= '0;
                cfg_ld_dma_stride[q]     <= '0;
            end
        end else begin
            for (int q = 0; q < QUEUE_DEPTH; q++) begin
                if (st_dma_invalidate_pulse[q]) begin
                    cfg_st_dma_valid[q] <= 1'b0;
                end else if (reg_wr_en &&
                             reg_addr == hdr_word(REG_ST_HDR_BASE, ST_HDR_WORDS, q,
                                                  HDR_VALIDATE)) begin
                    cfg_st_dma_valid[q] <= reg_wr_data[0];
                end
                if (ld_dma_invalidate_pulse[q]) begin
                    cfg_ld_dma_valid[q] <= 1'b0;
                end else if (reg_wr_en &&
                             reg_addr == hdr_word(REG_LD_HDR_BASE, LD_HDR_WORDS, q,
                                                  HDR_VALIDATE)) begin
                    cfg_ld_dma_valid[q] <= reg_wr_data[0];
                end

                if (reg_wr_en) begin
                    if (reg_addr == hdr_word(REG_ST_HDR_BASE, ST_HDR_WORDS, q,
                                             HDR_START_ADDR)) begin
                        cfg_st_dma_start_addr[q] <= reg_wr_data[GLB_ADDR_WIDTH-1:0];
                    end
                    if (reg_addr == hdr_word(REG_ST_HDR_BASE, ST_HDR_WORDS, q,
                                             HDR_NUM_WORDS)) begin
                        cfg_st_dma_num_words[q] <= reg_wr_data[NUM_WORDS_WIDTH-1:0];
                    end
                    if (reg_addr == hdr_word(REG_LD_HDR_BASE, LD_HDR_WORDS, q,
                                             HDR_START_ADDR)) begin
                        cfg_ld_dma_start_addr[q] <= reg_wr_data[GLB_ADDR_WIDTH-1:0];
                    end
                    if (reg_addr == hdr_word(REG_LD_HDR_BASE, LD_HDR_WORDS, q,
                                             HDR_NUM_WORDS)) begin
                        cfg_ld_dma_num_words[q] <= reg_wr_data[NUM_WORDS_WIDTH-1:0];
                    end
                    if (reg_addr == hdr_word(REG_LD_HDR_BASE, LD_HDR_WORDS, q,
                                             HDR_STRIDE)) begin
                        cfg_ld_dma_stride[q] <= reg_wr_data;
                    end
                end
            end
        end
    end

    // Read mux, unmapped words stay zero
    always_comb begin
        rd_word = '0;
        if (reg_addr == reg_addr_t'(REG_TILE_CTRL)) begin
            rd_word[CTRL_TILE_CONNECTED]    = cfg_tile_connected;
            rd_word[CTRL_G2F_MUX_LSB +: 2]  = cfg_strm_g2f_mux;
            rd_word[CTRL_F2G_MUX_LSB +: 2]  = cfg_strm_f2g_mux;
            rd_word[CTRL_LD_MODE_LSB +: 2]  = cfg_ld_dma_mode;
            rd_word[CTRL_ST_MODE_LSB +: 2]  = cfg_st_dma_mode;
            rd_word[CTRL_USE_VALID]         = cfg_use_valid;
        end
        if (reg_addr == reg_addr_t'(REG_LATENCY)) begin
            rd_word = cfg_data_t'(cfg_latency);
        end
        for (int q = 0; q < QUEUE_DEPTH; q++) begin
            if (reg_addr == hdr_word(REG_ST_HDR_BASE, ST_HDR_WORDS, q, HDR_VALIDATE)) begin
                rd_word = cfg_data_t'(cfg_st_dma_valid[q]);
            end
            if (reg_addr == hdr_word(REG_ST_HDR_BASE, ST_HDR_WORDS, q, HDR_START_ADDR)) begin
                rd_word = cfg_data_t'(cfg_st_dma_start_addr[q]);
            end
            if (reg_addr == hdr_word(REG_ST_HDR_BASE, ST_HDR_WORDS, q, HDR_NUM_WORDS)) begin
                rd_word = cfg_data_t'(cfg_st_dma_num_words[q]);
            end
            if (reg_addr == hdr_word(REG_LD_HDR_BASE, LD_HDR_WORDS, q, HDR_VALIDATE)) begin
                rd_word = cfg_data_t'(cfg_ld_dma_valid[q]);
            end
            if (reg_addr == hdr_word(REG_LD_HDR_BASE, LD_HDR_WORDS, q, HDR_START_ADDR)) begin
                rd_word = cfg_data_t'(cfg_ld_dma_start_addr[q]);
            end
            if (reg_addr == hdr_word(REG_LD_HDR_BASE, LD_HDR_WORDS, q, HDR_NUM_WORDS)) begin
                rd_word = cfg_data_t'(cfg_ld_dma_num_words[q]);
            end
            if (reg_addr == hdr_word(REG_LD_HDR_BASE, LD_HDR_WORDS, q, HDR_STRIDE)) begin
                rd_word = cfg_ld_dma_stride[q];
            end
        end
    end

    // Data only shows while a local read is active
    assign reg_rd_data = reg_rd_en ? rd_word : '0;

endmodule

`default_nettype wire

//--- glb_tile_cfg_tests.txt
# op, tile, reg index, data, expected (all hex); C uses tile as queue entry, reg as output select
# ops: W write and read back, R read, F foreign write, E east return, I invalidate, C check
C 0 f 0 0
R 3 0 0 0
R 3 d 0 0
W 3 0 ffffffff 3ff
W 3 0 00000156 156
C 0 0 0 0
C 0 1 0 3
C 0 2 0 2
C 0 3 0 2
C 0 4 0 2
C 0 5 0 0
W 3 1 ffffffe9 9
C 0 6 0 9
W 3 2 00000003 1
W 3 3 abcd1234 1234
W 3 4 00015678 5678
W 3 5 00000001 1
W 3 6 0000beef beef
W 3 7 12340042 42
W 3 8 00000001 1
W 3 9 5555aaaa aaaa
W 3 a 00000100 100
W 3 b 87654321 87654321
W 3 c 00000001 1
W 3 d 0000cafe cafe
W 3 e 00000020 20
W 3 f 00000004 4
R 3 10 0 0
R 3 3f 0 0
C 0 7 0 3
C 0 8 0 3
C 1 9 0 beef
C 0 b 0 aaaa
C 1 d 0 4
F 5 1 1f 504
R 3 1 0 9
E 7 0 a5a5f00d a5a5f00d
I f 2 1 0
C 0 7 0 2
I 3 c 8 0
C 0 8 0 1
R 3 c 0 0

//--- tb_glb_tile_cfg.sv
`timescale 1ns/1ns
`default_nettype none

module tb_glb_tile_cfg;

    import glb_cfg_pkg::*;

    localparam int RETURN_TIMEOUT = 20;

    logic       clk;
    logic       arst_n;
    tile_id_t   glb_tile_id;
    logic       cfg_wst_wr_en;
    logic       cfg_wst_rd_en;
    cfg_addr_t  cfg_wst_addr;
    cfg_data_t  cfg_wst_data;
    cfg_data_t  cfg_wst_rd_data;
    logic       cfg_wst_rd_data_valid;
    logic       cfg_est_wr_en;
    logic       cfg_est_rd_en;
    cfg_addr_t  cfg_est_addr;
    cfg_data_t  cfg_est_data;
    cfg_data_t  cfg_est_rd_data;
    logic       cfg_est_rd_data_valid;
    logic [QUEUE_DEPTH-1:0] st_dma_invalidate_pulse;
    logic [QUEUE_DEPTH-1:0] ld_dma_invalidate_pulse;
    logic       cfg_tile_connected;
    logic [1:0] cfg_strm_g2f_mux;
    logic [1:0] cfg_strm_f2g_mux;
    logic [1:0] cfg_ld_dma_mode;
    logic [1:0] cfg_st_dma_mode;
    logic       cfg_use_valid;
    latency_t   cfg_latency;
    logic [QUEUE_DEPTH-1:0] cfg_st_dma_valid;
    glb_addr_t  cfg_st_dma_start_addr [QUEUE_DEPTH];
    num_words_t cfg_st_dma_num_words  [QUEUE_DEPTH];
    logic [QUEUE_DEPTH-1:0] cfg_ld_dma_valid;
    glb_addr_t  cfg_ld_dma_start_addr [QUEUE_DEPTH];
    num_words_t cfg_ld_dma_num_words  [QUEUE_DEPTH];
    cfg_data_t  cfg_ld_dma_stride     [QUEUE_DEPTH];

    integer           seed;
    integer           fd;
    int               errors;
    int               tests;
    logic [8*128-1:0] text_line;
    logic [7:0]       op;
    tile_id_t         tile;
    reg_addr_t        idx;
    cfg_data_t        data;
    cfg_data_t        expected;

    glb_tile_cfg uut (.*);

    always #20 clk = ~clk;

    task automatic check_value(input string name, input cfg_data_t got, input cfg_data_t exp);
        assert (got === exp) else begin
            $display("[ERROR] %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        assert (cond) else begin
            $display("%s", what);
            errors++;
        end
    endtask

    // Output select codes of the C lines
    function automatic string output_name(input int sel);
        case (sel)
            0: return "cfg_tile_connected";
            1: return "cfg_strm_g2f_mux";
            2: return "cfg_strm_f2g_mux";
            3: return "cfg_ld_dma_mode";
            4: return "cfg_st_dma_mode";
            5: return "cfg_use_valid";
            6: return "cfg_latency";
            7: return "cfg_st_dma_valid";
            8: return "cfg_ld_dma_valid";
            9: return "cfg_st_dma_start_addr";
            10: return "cfg_st_dma_num_words";
            11: return "cfg_ld_dma_start_addr";
            12: return "cfg_ld_dma_num_words";
            13: return "cfg_ld_dma_stride";
            default: return "all cfg outputs";
        endcase
    endfunction

    function automatic cfg_data_t output_value(input int sel, input int q);
        cfg_data_t any_bits;
        any_bits = cfg_data_t'({cfg_tile_connected, cfg_strm_g2f_mux, cfg_strm_f2g_mux,
                                cfg_ld_dma_mode, cfg_st_dma_mode, cfg_use_valid, cfg_latency,
                                cfg_st_dma_valid, cfg_ld_dma_valid});
        for (int i = 0; i < QUEUE_DEPTH; i++) begin
            any_bits |= cfg_st_dma_start_addr[i] | cfg_st_dma_num_words[i] |
                        cfg_ld_dma_start_addr[i] | cfg_ld_dma_num_words[i] |
                        cfg_ld_dma_stride[i];
        end
        case (sel)
            0: return cfg_data_t'(cfg_tile_connected);
            1: return cfg_data_t'(cfg_strm_g2f_mux);
            2: return cfg_data_t'(cfg_strm_f2g_mux);
            3: return cfg_data_t'(cfg_ld_dma_mode);
            4: return cfg_data_t'(cfg_st_dma_mode);
            5: return cfg_data_t'(cfg_use_valid);
            6: return cfg_data_t'(cfg_latency);
            7: return cfg_data_t'(cfg_st_dma_valid);
            8: return cfg_data_t'(cfg_ld_dma_valid);
            9: return cfg_data_t'(cfg_st_dma_start_addr[q]);
            10: return cfg_data_t'(cfg_st_dma_num_words[q]);
            11: return cfg_data_t'(cfg_ld_dma_start_addr[q]);
            12: return cfg_data_t'(cfg_ld_dma_num_words[q]);
            13: return cfg_ld_dma_stride[q];
            default: return any_bits;
        endcase
    endfunction

    // Idle cycle with random data on the west bus
    task automatic idle_cycle();
        @(posedge clk);
        cfg_wst_wr_en           <= 1'b0;
        cfg_wst_rd_en           <= 1'b0;
        cfg_wst_data            <= $random(seed);
        cfg_est_rd_data_valid   <= 1'b0;
        st_dma_invalidate_pulse <= '0;
        ld_dma_invalidate_pulse <= '0;
    endtask

    task automatic send_request(input logic wr, input logic rd, input cfg_addr_t addr,
                                input cfg_data_t wdata);
        @(posedge clk);
        cfg_wst_wr_en <= wr;
        cfg_wst_rd_en <= rd;
        cfg_wst_addr  <= addr;
        cfg_wst_data  <= wdata;
    endtask

    // Cycles counted from the first idle edge up to the west return
    task automatic wait_return(output int cycles);
        logic seen;
        seen   = 1'b0;
        cycles = 0;
        while (!seen && cycles < RETURN_TIMEOUT) begin
            idle_cycle();
            @(negedge clk);
            seen = cfg_wst_rd_data_valid;
            cycles++;
        end
        check_true(seen, "Timed out waiting for read data on the west port");
    endtask

    task automatic read_back(input cfg_addr_t addr, input cfg_data_t exp);
        int cycles;
        send_request(1'b0, 1'b1, addr, '0);
        wait_return(cycles);
        check_true(cycles == 2, "Local read data came back with the wrong latency");
        check_value("cfg_wst_rd_data", cfg_wst_rd_data, exp);
    endtask

    task automatic run_test(input logic [7:0] code, input tile_id_t t, input reg_addr_t r,
                            input cfg_data_t d, input cfg_data_t exp);
        cfg_addr_t addr;
        int        cycles;
        addr = {t, r, 2'b00};
        case (code)
            "W": begin
                send_request(1'b1, 1'b0, addr, d);
                read_back(addr, exp);
            end
            "R": read_back(addr, exp);
            "F": begin
                send_request(1'b1, 1'b0, addr, d);
                idle_cycle();
                @(negedge clk);
                check_value("cfg_est_wr_en", cfg_data_t'(cfg_est_wr_en), 32'h1);
                check_value("cfg_est_addr", cfg_data_t'(cfg_est_addr), exp);
                check_value("cfg_est_data", cfg_est_data, d);
                idle_cycle();
            end
            "E": begin
                send_request(1'b0, 1'b1, addr, '0);
                idle_cycle();
                @(negedge clk);
                check_value("cfg_est_rd_en", cfg_data_t'(cfg_est_rd_en), 32'h1);
                check_value("cfg_est_addr", cfg_data_t'(cfg_est_addr), cfg_data_t'(addr));
                idle_cycle();
                cfg_est_rd_data       <= d;
                cfg_est_rd_data_valid <= 1'b1;
                wait_return(cycles);
                check_true(cycles == 1, "East return did not reach the west after one cycle");
                check_value("cfg_wst_rd_data", cfg_wst_rd_data, exp);
            end
            "I": begin
                // Pulse is sampled on the same edge that applies the write
                send_request(1'b1, 1'b0, addr, 32'h1);
                idle_cycle();
                st_dma_invalidate_pulse <= d[1:0];
                ld_dma_invalidate_pulse <= d[3:2];
                idle_cycle();
            end
            "C": begin
                @(negedge clk);
                check_value($sformatf("%s entry %0d", output_name(r), t),
                            output_value(r, t), exp);
            end
            default: check_true(1'b0, "Unknown operation code in the test file");
        endcase
    endtask

    initial begin
        int err_before;
        seed                    = 39;
        errors                  = 0;
        tests                   = 0;
        clk                     = 1'b0;
        arst_n                  = 1'b0;
        glb_tile_id             = 4'h3;
        cfg_wst_wr_en           = 1'b0;
        cfg_wst_rd_en           = 1'b0;
        cfg_wst_addr            = '0;
        cfg_wst_data            = '0;
        cfg_est_rd_data         = '0;
        cfg_est_rd_data_valid   = 1'b0;
        st_dma_invalidate_pulse = '0;
        ld_dma_invalidate_pulse = '0;
        repeat (3) @(posedge clk);
        arst_n <= 1'b1;

        fd = $fopen("glb_tile_cfg_tests.txt", "r");
        check_true(fd != 0, "Could not open glb_tile_cfg_tests.txt");
        while (fd != 0 && !$feof(fd)) begin
            text_line = '0;
            if ($fgets(text_line, fd) != 0 &&
                $sscanf(text_line, "%s %h %h %h %h", op, tile, idx, data, expected) == 5) begin
                err_before = errors + uut.u_assert.fail_count;
                tests++;
                run_test(op, tile, idx, data, expected);
                $display("Test %0d (%s tile %h reg %h) %s", tests, op, tile, idx,
                         (errors + uut.u_assert.fail_count == err_before) ? "ok" : "failed");
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end

        // Bound assertion failures count as errors too
        errors += uut.u_assert.fail_count;
        $display("Tests run: %0d, errors: %0d", tests, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
